/* verilog/camera_cmd_pkg.sv */
/*
 * Camera command definitions
 * Opcodes, response and operand types, and the capture state encoding
 */
package camera_cmd_pkg;

    typedef logic [7:0] opcode_t;
    typedef logic [7:0] response_t;
    typedef logic [1:0] operand_count_t;

    // Host opcodes
    localparam opcode_t OP_CAPTURE         = 8'h20;
    localparam opcode_t OP_BYTES_AVAILABLE = 8'h21;
    localparam opcode_t OP_READ_DATA       = 8'h22;
    localparam opcode_t OP_METERING        = 8'h25;

    // Capture waits in ARMED for the next frame start
    typedef enum logic [1:0] {
        IDLE,
        ARMED,
        ACTIVE
    } capture_state_t;

endpackage

/* verilog/camera_pixel_pkg.sv */
/*
 * Camera pixel path definitions
 * Pixel widths, crop window and image buffer geometry
 */
package camera_pixel_pkg;

    typedef logic [9:0]  raw_pixel_t;
    typedef logic [7:0]  pixel_byte_t;
    typedef logic [31:0] buffer_word_t;
    typedef logic [15:0] byte_count_t;
    typedef logic [3:0]  word_address_t;

    // Crop window, start inclusive and end exclusive
    localparam byte_count_t X_CROP_START = 16'd4;
    localparam byte_count_t X_CROP_END   = 16'd12;
    localparam byte_count_t Y_CROP_START = 16'd2;
    localparam byte_count_t Y_CROP_END   = 16'd6;

    // 8 x 4 window
    localparam byte_count_t CAPTURE_BYTES      = 16'd32;
    localparam int          CAPTURE_BYTES_LOG2 = 5;

    localparam int BUFFER_WORDS = 16;

endpackage

/* verilog/buffer_read_if.sv */
/*
 * Image buffer byte read port
 * Four-phase req/ack handshake between controller and memory
 */
interface buffer_read_if;
    import camera_pixel_pkg::*;

    logic        req;
    logic        ack;
    byte_count_t address;
    pixel_byte_t data;

    modport controller (output req, output address, input ack, input data);
    modport memory (input req, input address, output ack, output data);

endinterface

/* verilog/crop.sv */
/*
 * Crop
 * Tracks pixel position and passes only the pixels inside the crop window
 */
module crop (
    input  logic                          clock_spi_in,
    input  logic                          mipi_byte_reset_n,
    input  camera_pixel_pkg::raw_pixel_t  pixel_i,
    input  logic                          line_valid_i,
    input  logic                          frame_valid_i,
    output camera_pixel_pkg::pixel_byte_t pixel_o,
    output logic                          pixel_valid_o,
    output logic                          frame_valid_o
);
    import camera_pixel_pkg::*;

    byte_count_t x_count;
    byte_count_t y_count;
    logic        line_valid_d;
    logic        in_window;

    assign in_window = x_count >= X_CROP_START && x_count < X_CROP_END &&
                       y_count >= Y_CROP_START && y_count < Y_CROP_END;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count       <= '0;
            y_count       <= '0;
            line_valid_d  <= 1'b0;
            pixel_valid_o <= 1'b0;
            frame_valid_o <= 1'b0;
        end else begin
            line_valid_d  <= line_valid_i;
            frame_valid_o <= frame_valid_i;
            pixel_valid_o <= frame_valid_i && line_valid_i && in_window;

            // frame_valid_o is also the delayed flag for the frame start edge
            if (frame_valid_i && !frame_valid_o) begin
                x_count <= '0;
                y_count <= '0;
            end else if (line_valid_i) begin
                x_count <= x_count + 1'b1;
            end else if (line_valid_d) begin
                // End of line
                x_count <= '0;
                y_count <= y_count + 1'b1;
            end
        end
    end

    // Keep the top eight bits of the raw pixel
    always_ff @(posedge clock_spi_in) begin
        pixel_o <= pixel_i[$bits(raw_pixel_t)-1 -: $bits(pixel_byte_t)];
    end

endmodule

/* verilog/metering.sv */
/*
 * Metering
 * Averages the cropped pixels of each frame into one brightness byte
 */
module metering (
    input  logic                          clock_spi_in,
    input  logic                          mipi_byte_reset_n,
    input  camera_pixel_pkg::pixel_byte_t pixel_i,
    input  logic                          pixel_valid_i,
    input  logic                          frame_valid_i,
    output camera_pixel_pkg::pixel_byte_t metering_o
);
    import camera_pixel_pkg::*;

    // Wide enough for CAPTURE_BYTES full-scale pixels
    logic [$bits(pixel_byte_t)+CAPTURE_BYTES_LOG2-1:0] sum;
    byte_count_t pixel_count;
    logic        frame_valid_d;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            sum           <= '0;
            pixel_count   <= '0;
            frame_valid_d <= 1'b0;
            metering_o    <= '0;
        end else begin
            frame_valid_d <= frame_valid_i;

            if (frame_valid_i && !frame_valid_d) begin
                sum         <= '0;
                pixel_count <= '0;
            end else if (pixel_valid_i) begin
                sum         <= sum + pixel_i;
                pixel_count <= pixel_count + 1'b1;
            end

            // Frame end, divide by the window size
            if (!frame_valid_i && frame_valid_d) begin
                metering_o <= sum[CAPTURE_BYTES_LOG2 +: $bits(pixel_byte_t)];
            end
        end
    end

    // Crop must never deliver more pixels than the window holds
    assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        pixel_valid_i |-> pixel_count < CAPTURE_BYTES)
        else $error("metering: more than CAPTURE_BYTES pixels in one frame");

endmodule

/* verilog/pixel_packer.sv */
/*
 * Pixel packer
 * Packs four cropped pixels per buffer word and writes them during a capture
 */
module pixel_packer (
    input  logic                            clock_spi_in,
    input  logic                            mipi_byte_reset_n,
    input  logic                            capture_active_i,
    input  camera_pixel_pkg::pixel_byte_t   pixel_i,
    input  logic                            pixel_valid_i,
    output camera_pixel_pkg::word_address_t write_address_o,
    output camera_pixel_pkg::buffer_word_t  write_data_o,
    output logic                            write_enable_o,
    output camera_pixel_pkg::byte_count_t   bytes_written_o
);
    import camera_pixel_pkg::*;

    logic [1:0]   lane;
    logic         capture_active_d;
    buffer_word_t packed_word;

    assign write_data_o = packed_word;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            lane             <= '0;
            capture_active_d <= 1'b0;
            write_address_o  <= '0;
            write_enable_o   <= 1'b0;
            bytes_written_o  <= '0;
        end else begin
            capture_active_d <= capture_active_i;
            write_enable_o   <= 1'b0;

            if (capture_active_i && !capture_active_d) begin
                lane            <= '0;
                write_address_o <= '0;
                bytes_written_o <= '0;
            end else begin
                if (capture_active_i && pixel_valid_i) begin
                    lane           <= lane + 1'b1;
                    write_enable_o <= lane == 2'd3;
                end
                if (write_enable_o) begin
                    write_address_o <= write_address_o + 1'b1;
                    bytes_written_o <= bytes_written_o + 16'd4;
                end
            end
        end
    end

    // Shift in from the top so the first pixel lands in the low byte
    always_ff @(posedge clock_spi_in) begin
        if (capture_active_i && pixel_valid_i) begin
            packed_word <= {pixel_i,
                            packed_word[$bits(buffer_word_t)-1:$bits(pixel_byte_t)]};
        end
    end

    // The 4-bit address wraps silently, the byte count shows the overrun
    assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        write_enable_o |-> bytes_written_o < BUFFER_WORDS * 4)
        else $error("pixel_packer: write past the end of the image buffer");

endmodule

/* verilog/image_buffer.sv */
/*
 * Image buffer
 * Word-wide write port, byte-wide read port served with a four-phase handshake
 */
module image_buffer (
    input  logic                            clock_spi_in,
    input  logic                            mipi_byte_reset_n,
    input  camera_pixel_pkg::word_address_t write_address_i,
    input  camera_pixel_pkg::buffer_word_t  write_data_i,
    input  logic                            write_enable_i,
    buffer_read_if.memory                   read
);
    import camera_pixel_pkg::*;

    buffer_word_t memory [BUFFER_WORDS];
    buffer_word_t read_word;

    // Byte address bits 1:0 pick the lane within the word
    assign read_word = memory[read.address[2 +: $bits(word_address_t)]];

    always_ff @(posedge clock_spi_in) begin
        if (write_enable_i) begin
            memory[write_address_i] <= write_data_i;
        end
        if (read.req && !read.ack) begin
            read.data <= read_word[{read.address[1:0], 3'b000} +: $bits(pixel_byte_t)];
        end
    end

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            read.ack <= 1'b0;
        end else if (read.req && !read.ack) begin
            read.ack <= 1'b1;
        end else if (!read.req) begin
            read.ack <= 1'b0;
        end
    end

    // The request must still stand when its byte is delivered
    assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        $rose(read.ack) |-> read.req)
        else $error("image_buffer: ack raised without a request");

endmodule

/* verilog/camera_control.sv */
/*
 * Camera controller
 * Decodes host opcodes, runs the capture FSM and prefetches read bytes
 */
module camera_control (
    input  logic                           clock_spi_in,
    input  logic                           mipi_byte_reset_n,
    input  camera_cmd_pkg::opcode_t        op_code_i,
    input  logic                           op_code_valid_i,
    input  logic                           operand_valid_i,
    input  camera_cmd_pkg::operand_count_t operand_count_i,
    input  logic                           frame_valid_i,
    input  camera_pixel_pkg::byte_count_t  bytes_written_i,
    input  camera_pixel_pkg::pixel_byte_t  metering_i,
    output logic                           capture_active_o,
    output camera_cmd_pkg::response_t      response_o,
    output logic                           response_valid_o,
    buffer_read_if.controller              read
);
    import camera_cmd_pkg::*;
    import camera_pixel_pkg::*;

    capture_state_t state;
    logic           frame_valid_d;
    logic           operand_valid_d;
    logic           capture_cmd;
    logic           advance;
    logic           prefetch_pending;
    logic           prefetch_issue;
    byte_count_t    bytes_read;
    byte_count_t    bytes_written_d;
    byte_count_t    bytes_available;
    response_t      read_byte;

    // Capture is only accepted while idle
    assign capture_cmd = op_code_valid_i && op_code_i == OP_CAPTURE && state == IDLE;

    // Rising operand strobe during a read moves to the next byte
    assign advance = op_code_valid_i && op_code_i == OP_READ_DATA &&
                     operand_valid_i && !operand_valid_d;

    assign prefetch_issue   = prefetch_pending && !read.req && !read.ack;
    assign bytes_available  = bytes_written_i - bytes_read;
    assign capture_active_o = state == ACTIVE;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state         <= IDLE;
            frame_valid_d <= 1'b0;
        end else begin
            frame_valid_d <= frame_valid_i;
            case (state)
                IDLE: begin
                    if (capture_cmd) state <= ARMED;
                end
                ARMED: begin
                    if (frame_valid_i && !frame_valid_d) state <= ACTIVE;
                end
                ACTIVE: begin
                    if (!frame_valid_i && frame_valid_d) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Read pointer and prefetch handshake
    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            operand_valid_d  <= 1'b0;
            bytes_read       <= '0;
            bytes_written_d  <= '0;
            prefetch_pending <= 1'b0;
            read.req         <= 1'b0;
        end else begin
            operand_valid_d <= operand_valid_i;
            bytes_written_d <= bytes_written_i;

            if (capture_cmd) begin
                bytes_read <= '0;
            end else if (advance) begin
                bytes_read <= bytes_read + 1'b1;
            end

            if (prefetch_issue) begin
                read.req         <= 1'b1;
                prefetch_pending <= 1'b0;
            end else if (read.req && read.ack) begin
                read.req <= 1'b0;
            end

            // New data in the buffer or a moved pointer needs a fresh byte
            if (advance || bytes_written_i != bytes_written_d) begin
                prefetch_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock_spi_in) begin
        if (prefetch_issue) begin
            read.address <= bytes_read;
        end
        if (read.req && read.ack) begin
            read_byte <= read.data;
        end
    end

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            response_o       <= '0;
            response_valid_o <= 1'b0;
        end else begin
            response_valid_o <= 1'b0;
            if (op_code_valid_i) begin
                case (op_code_i)
                    OP_BYTES_AVAILABLE: begin
                        // High byte first
                        response_o <= operand_count_i == '0 ? bytes_available[15:8]
                                                           : bytes_available[7:0];
                        response_valid_o <= 1'b1;
                    end
                    OP_READ_DATA: begin
                        response_o       <= read_byte;
                        response_valid_o <= 1'b1;
                    end
                    OP_METERING: begin
                        response_o       <= metering_i;
                        response_valid_o <= 1'b1;
                    end
                    default: response_valid_o <= 1'b0;
                endcase
            end
        end
    end

    assert property (@(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        state inside {IDLE, ARMED, ACTIVE})
        else $error("camera_control: illegal capture state");

endmodule

/* verilog/camera.sv */
/*
 * Camera capture top level
 * Crop, metering, packing and image buffer behind a byte-wide command port
 */
module camera (
    input  logic                           clock_spi_in,
    input  logic                           mipi_byte_reset_n,
    input  camera_pixel_pkg::raw_pixel_t   pixel_i,
    input  logic                           line_valid_i,
    input  logic                           frame_valid_i,
    input  camera_cmd_pkg::opcode_t        op_code_i,
    input  logic                           op_code_valid_i,
    input  logic                           operand_valid_i,
    input  camera_cmd_pkg::operand_count_t operand_count_i,
    output camera_cmd_pkg::response_t      response_o,
    output logic                           response_valid_o
);
    import camera_pixel_pkg::*;

    pixel_byte_t   crop_pixel;
    logic          crop_pixel_valid;
    logic          crop_frame_valid;
    pixel_byte_t   metering;
    logic          capture_active;
    byte_count_t   bytes_written;
    word_address_t write_address;
    buffer_word_t  write_data;
    logic          write_enable;

    buffer_read_if read_bus ();

    crop crop_inst (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (pixel_i),
        .line_valid_i      (line_valid_i),
        .frame_valid_i     (frame_valid_i),
        .pixel_o           (crop_pixel),
        .pixel_valid_o     (crop_pixel_valid),
        .frame_valid_o     (crop_frame_valid)
    );

    metering metering_inst (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (crop_pixel),
        .pixel_valid_i     (crop_pixel_valid),
        .frame_valid_i     (crop_frame_valid),
        .metering_o        (metering)
    );

    pixel_packer pixel_packer_inst (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .capture_active_i  (capture_active),
        .pixel_i           (crop_pixel),
        .pixel_valid_i     (crop_pixel_valid),
        .write_address_o   (write_address),
        .write_data_o      (write_data),
        .write_enable_o    (write_enable),
        .bytes_written_o   (bytes_written)
    );

    image_buffer image_buffer_inst (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .write_address_i   (write_address),
        .write_data_i      (write_data),
        .write_enable_i    (write_enable),
        .read              (read_bus.memory)
    );

    // Capture follows the raw frame flag, ahead of the cropped pixels
    camera_control camera_control_inst (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .op_code_i         (op_code_i),
        .op_code_valid_i   (op_code_valid_i),
        .operand_valid_i   (operand_valid_i),
        .operand_count_i   (operand_count_i),
        .frame_valid_i     (frame_valid_i),
        .bytes_written_i   (bytes_written),
        .metering_i        (metering),
        .capture_active_o  (capture_active),
        .response_o        (response_o),
        .response_valid_o  (response_valid_o),
        .read              (read_bus.controller)
    );

endmodule

/* verif/camera_tb.sv */
/*
 * Camera testbench
 * Directed tests of capture, byte readback and metering through the command port
 */
module camera_tb;
    import camera_cmd_pkg::*;
    import camera_pixel_pkg::*;

    localparam int          FRAME_WIDTH   = 16;
    localparam int          FRAME_HEIGHT  = 8;
    localparam int          LINE_GAP      = 2;
    localparam int          RESPONSE_WAIT = 16;
    localparam int unsigned CYCLE_LIMIT   = 6000;
    localparam logic [31:0] LFSR_TAPS     = 32'h80200003;

    logic           clock_spi_in = 1'b0;
    logic           mipi_byte_reset_n;
    raw_pixel_t     pixel;
    logic           line_valid;
    logic           frame_valid;
    opcode_t        op_code;
    logic           op_code_valid;
    logic           operand_valid;
    operand_count_t operand_count;
    response_t      response;
    logic           response_valid;

    logic [31:0]    lfsr_state = 32'h5276a84f;
    int unsigned    cycle_count = 0;
    // Window bytes of the most recent frame, row-major
    pixel_byte_t    expected_bytes[$];

    camera camera_inst (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (pixel),
        .line_valid_i      (line_valid),
        .frame_valid_i     (frame_valid),
        .op_code_i         (op_code),
        .op_code_valid_i   (op_code_valid),
        .operand_valid_i   (operand_valid),
        .operand_count_i   (operand_count),
        .response_o        (response),
        .response_valid_o  (response_valid)
    );

    always #4 clock_spi_in = ~clock_spi_in;

    always @(posedge clock_spi_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            report_failure($sformatf("Timeout, tests still running after %0d cycles",
                                     CYCLE_LIMIT));
        end
    end

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic compare_response(input string test_name, input response_t expected,
                                    input response_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error %s: expected %0h, actual %0h",
                                     test_name, expected, actual));
        end
    endtask

    task automatic check_byte_count(input string test_name, input byte_count_t expected,
                                    input byte_count_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error %s: expected %0d, actual %0d",
                                     test_name, expected, actual));
        end
    endtask

    task automatic verify_pixel(input string test_name, input pixel_byte_t expected,
                                input pixel_byte_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error %s: expected %0h, actual %0h",
                                     test_name, expected, actual));
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next_state;
        next_state = state >> 1;
        if (state[0]) next_state = next_state ^ LFSR_TAPS;
        return next_state;
    endfunction

    // One LFSR step per pixel bit
    task automatic random_pixel(output raw_pixel_t value);
        value = '0;
        for (int i = 0; i < $bits(raw_pixel_t); i++) begin
            value      = {value[$bits(raw_pixel_t)-2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic send_frame();
        raw_pixel_t value;
        expected_bytes.delete();
        frame_valid = 1'b1;
        repeat (LINE_GAP) @(negedge clock_spi_in);
        for (int y = 0; y < FRAME_HEIGHT; y++) begin
            for (int x = 0; x < FRAME_WIDTH; x++) begin
                random_pixel(value);
                pixel      = value;
                line_valid = 1'b1;
                if (x >= X_CROP_START && x < X_CROP_END &&
                    y >= Y_CROP_START && y < Y_CROP_END) begin
                    expected_bytes.push_back(value[9:2]);
                end
                @(negedge clock_spi_in);
            end
            line_valid = 1'b0;
            repeat (LINE_GAP) @(negedge clock_spi_in);
        end
        frame_valid = 1'b0;
        repeat (4) @(negedge clock_spi_in);
    endtask

    task automatic await_response(input logic level);
        int waited = 0;
        while (response_valid !== level) begin
            if (waited == RESPONSE_WAIT) begin
                report_failure($sformatf("response_valid_o did not go to %0b within %0d cycles",
                                         level, RESPONSE_WAIT));
            end
            waited++;
            @(negedge clock_spi_in);
        end
    endtask

    task automatic issue_capture();
        op_code       = OP_CAPTURE;
        op_code_valid = 1'b1;
        @(negedge clock_spi_in);
        op_code_valid = 1'b0;
        @(negedge clock_spi_in);
    endtask

    task automatic run_command(input opcode_t op, input operand_count_t count,
                               output response_t value);
        op_code       = op;
        operand_count = count;
        op_code_valid = 1'b1;
        @(negedge clock_spi_in);
        await_response(1'b1);
        value         = response;
        op_code_valid = 1'b0;
        @(negedge clock_spi_in);
        await_response(1'b0);
    endtask

    // High byte with operand 0, low byte with operand 1
    task automatic query_available(output byte_count_t count);
        response_t high_byte;
        response_t low_byte;
        run_command(OP_BYTES_AVAILABLE, 2'd0, high_byte);
        run_command(OP_BYTES_AVAILABLE, 2'd1, low_byte);
        count = {high_byte, low_byte};
    endtask

    task automatic fetch_byte(output response_t value);
        op_code       = OP_READ_DATA;
        op_code_valid = 1'b1;
        @(negedge clock_spi_in);
        await_response(1'b1);
        value = response;
        // Operand strobe moves the pointer, the prefetch needs under 6 cycles
        operand_valid = 1'b1;
        @(negedge clock_spi_in);
        operand_valid = 1'b0;
        repeat (6) @(negedge clock_spi_in);
        op_code_valid = 1'b0;
        @(negedge clock_spi_in);
        await_response(1'b0);
    endtask

    task automatic drain_frame(input string test_name, input bit track_available);
        response_t   value;
        byte_count_t available;
        for (int i = 0; i < CAPTURE_BYTES; i++) begin
            fetch_byte(value);
            verify_pixel(test_name, expected_bytes[i], value);
            if (track_available) begin
                query_available(available);
                check_byte_count(test_name, CAPTURE_BYTES - byte_count_t'(i + 1), available);
            end
        end
    endtask

    task automatic idle_after_reset();
        response_t value;
        repeat (8) begin
            @(negedge clock_spi_in);
            if (response_valid !== 1'b0) begin
                report_failure("response_valid_o went high before any command was sent");
            end
        end
        run_command(OP_BYTES_AVAILABLE, 2'd0, value);
        compare_response("idle_after_reset high", 8'h00, value);
        run_command(OP_BYTES_AVAILABLE, 2'd1, value);
        compare_response("idle_after_reset low", 8'h00, value);
    endtask

    task automatic frame_without_capture();
        byte_count_t available;
        send_frame();
        query_available(available);
        check_byte_count("frame_without_capture", 16'd0, available);
    endtask

    task automatic capture_mid_frame();
        response_t value;
        fork
            send_frame();
            begin
                repeat (40) @(negedge clock_spi_in);
                issue_capture();
            end
        join
        // The capture is already active here and must be ignored
        fork
            send_frame();
            begin
                repeat (60) @(negedge clock_spi_in);
                issue_capture();
            end
        join
        run_command(OP_BYTES_AVAILABLE, 2'd0, value);
        compare_response("capture_mid_frame high", 8'h00, value);
        run_command(OP_BYTES_AVAILABLE, 2'd1, value);
        compare_response("capture_mid_frame low", 8'd32, value);
    endtask

    task automatic readback_in_order();
        drain_frame("readback_in_order", 1'b1);
    endtask

    task automatic metering_average();
        int        sum = 0;
        response_t value;
        foreach (expected_bytes[i]) sum += expected_bytes[i];
        run_command(OP_METERING, 2'd0, value);
        compare_response("metering_average", response_t'(sum >> 5), value);
    endtask

    task automatic second_capture();
        byte_count_t available;
        issue_capture();
        send_frame();
        query_available(available);
        check_byte_count("second_capture", CAPTURE_BYTES, available);
        drain_frame("second_capture", 1'b0);
    endtask

    initial begin
        mipi_byte_reset_n = 1'b0;
        pixel             = '0;
        line_valid        = 1'b0;
        frame_valid       = 1'b0;
        op_code           = '0;
        op_code_valid     = 1'b0;
        operand_valid     = 1'b0;
        operand_count     = '0;
        repeat (10) @(negedge clock_spi_in);
        mipi_byte_reset_n = 1'b1;

        idle_after_reset();
        frame_without_capture();
        capture_mid_frame();
        readback_in_order();
        metering_average();
        second_capture();

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* compile.f */
verilog/camera_cmd_pkg.sv
verilog/camera_pixel_pkg.sv
verilog/buffer_read_if.sv
verilog/crop.sv
verilog/metering.sv
verilog/pixel_packer.sv
verilog/image_buffer.sv
verilog/camera_control.sv
verilog/camera.sv
verif/camera_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the camera testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module camera_tb -f compile.f -o camera_sim

output=$(./obj_dir/camera_sim) || true
echo "$output"

if echo "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
